/* Makefile */
TOP = corrChannelTb

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | \
		awk '{ print } /^Everything OK$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* sim.f */
src/corrPkg.sv
src/corrRegs.sv
src/corrCtrl.sv
src/chipTimer.sv
src/prnGen.sv
src/carrierMixAccum.sv
src/corrChannel.sv
verification/corrChannel_assertions.sv
verification/corrChannelTb.sv

/* src/carrierMixAccum.sv */
`timescale 1ns/1ps

module carrierMixAccum (
    input  logic                                adc,
    input  logic                                arstN,
    input  logic                                run,
    input  logic                                clearAcc,
    input  logic [corrPkg::NCO_W-1:0]           phaseRate,
    input  logic                                chip,
    input  logic signed [corrPkg::SAMPLE_W-1:0] adcData,
    output logic signed [corrPkg::ACC_W-1:0]    accI,
    output logic signed [corrPkg::ACC_W-1:0]    accQ
);

    logic [corrPkg::NCO_W-1:0]        carrPhase;
    logic [1:0]                       quadrant;
    logic                             cosNeg;
    logic                             sinNeg;
    logic signed [corrPkg::ACC_W-1:0] sampleExt;
    logic signed [corrPkg::ACC_W-1:0] termI;
    logic signed [corrPkg::ACC_W-1:0] termQ;

    assign quadrant = carrPhase[corrPkg::NCO_W-1 -: 2];
    // cos negative in quadrants 1 and 2
    assign cosNeg   = quadrant[1] ^ quadrant[0];
    // sin negative in quadrants 2 and 3
    assign sinNeg   = quadrant[1];

    assign sampleExt = {{(corrPkg::ACC_W-corrPkg::SAMPLE_W){adcData[corrPkg::SAMPLE_W-1]}},
                        adcData};

    // chip and carrier signs combine into one flip per arm
    assign termI = (chip ^ cosNeg) ? -sampleExt : sampleExt;
    assign termQ = (chip ^ sinNeg) ? -sampleExt : sampleExt;

    always_ff @(posedge adc or negedge arstN) begin
        if (!arstN) begin
            carrPhase <= '0;
        end else if (!run) begin
            carrPhase <= '0;
        end else begin
            carrPhase <= carrPhase + phaseRate;
        end
    end

    // results stay readable until the next start
    always_ff @(posedge adc or negedge arstN) begin
        if (!arstN) begin
            accI <= '0;
            accQ <= '0;
        end else if (clearAcc) begin
            accI <= '0;
            accQ <= '0;
        end else if (run) begin
            // wraps at ACC_W bits
            accI <= accI + termI;
            accQ <= accQ + termQ;
        end
    end

endmodule

/* src/chipTimer.sv */
`timescale 1ns/1ps

module chipTimer (
    input  logic                        adc,
    input  logic                        arstN,
    input  logic                        run,
    input  logic [corrPkg::NCO_W-1:0]   codeRate,
    input  logic [corrPkg::EPOCH_W-1:0] epochLen,
    output logic                        chipTick,
    output logic                        epochEnd
);

    logic [corrPkg::NCO_W-1:0]   codePhase;
    logic [corrPkg::NCO_W:0]     phaseSum;
    logic [corrPkg::EPOCH_W-1:0] chipCount;
    logic [corrPkg::EPOCH_W-1:0] countNext;

    // extra top bit catches the carry
    assign phaseSum = {1'b0, codePhase} + {1'b0, codeRate};
    assign chipTick = run && phaseSum[corrPkg::NCO_W];

    // chips completed including this tick
    assign countNext = chipCount + 1'b1;
    assign epochEnd  = chipTick && (countNext == epochLen);

    always_ff @(posedge adc or negedge arstN) begin
        if (!arstN) begin
            codePhase <= '0;
            chipCount <= '0;
        end else if (!run) begin
            // held at zero between epochs
            codePhase <= '0;
            chipCount <= '0;
        end else begin
            codePhase <= phaseSum[corrPkg::NCO_W-1:0];
            if (chipTick) begin
                chipCount <= countNext;
            end
        end
    end

endmodule

/* src/corrChannel.sv */
`timescale 1ns/1ps

module corrChannel (
    input  logic                                adc,
    input  logic                                arstN,
    input  logic                                wbCyc,
    input  logic                                wbStb,
    input  logic                                wbWe,
    input  logic [corrPkg::ADR_W-1:0]           wbAdr,
    input  logic [corrPkg::DAT_W-1:0]           wbDatW,
    output logic [corrPkg::DAT_W-1:0]           wbDatR,
    output logic                                wbAck,
    input  logic signed [corrPkg::SAMPLE_W-1:0] adcData,
    output logic                                irq
);

    // configuration from the register block
    logic                             startReq;
    logic                             enable;
    logic [corrPkg::NCO_W-1:0]        phaseRate;
    logic [corrPkg::NCO_W-1:0]        codeRate;
    logic [corrPkg::EPOCH_W-1:0]      epochLen;
    logic [corrPkg::PRN_W-1:0]        prnSeed;
    logic [corrPkg::PRN_W-1:0]        prnTaps;

    // epoch control and timing
    logic                             run;
    logic                             clearAcc;
    logic                             done;
    logic                             chipTick;
    logic                             epochEnd;
    logic                             chip;

    // results back to the bus
    logic signed [corrPkg::ACC_W-1:0] accI;
    logic signed [corrPkg::ACC_W-1:0] accQ;

    corrRegs i_regs (
        .adc(adc), .arstN(arstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .done(done), .run(run), .accI(accI), .accQ(accQ),
        .startReq(startReq), .enable(enable), .phaseRate(phaseRate),
        .codeRate(codeRate), .epochLen(epochLen), .prnSeed(prnSeed), .prnTaps(prnTaps)
    );

    corrCtrl i_ctrl (
        .adc(adc), .arstN(arstN), .startReq(startReq), .enable(enable),
        .epochEnd(epochEnd), .run(run), .clearAcc(clearAcc), .done(done), .irq(irq)
    );

    chipTimer i_chipTimer (
        .adc(adc), .arstN(arstN), .run(run), .codeRate(codeRate),
        .epochLen(epochLen), .chipTick(chipTick), .epochEnd(epochEnd)
    );

    prnGen i_prn (
        .adc(adc), .arstN(arstN), .run(run), .chipTick(chipTick),
        .prnSeed(prnSeed), .prnTaps(prnTaps), .chip(chip)
    );

    carrierMixAccum i_mix (
        .adc(adc), .arstN(arstN), .run(run), .clearAcc(clearAcc),
        .phaseRate(phaseRate), .chip(chip), .adcData(adcData),
        .accI(accI), .accQ(accQ)
    );

endmodule

/* src/corrCtrl.sv */
`timescale 1ns/1ps

module corrCtrl (
    input  logic adc,
    input  logic arstN,
    input  logic startReq,
    input  logic enable,
    input  logic epochEnd,
    output logic run,
    output logic clearAcc,
    output logic done,
    output logic irq
);

    corrPkg::corrState_t state;
    corrPkg::corrState_t nextState;

    // accepted start, clears the accumulators on the edge into run
    assign clearAcc = startReq && enable && (state == corrPkg::CORR_IDLE);
    // enable low drops run at once, abort completes on the next edge
    assign run      = (state == corrPkg::CORR_RUN) && enable;
    // one cycle in dump
    assign irq      = (state == corrPkg::CORR_DUMP);

    always_comb begin
        nextState = state;
        case (state)
            corrPkg::CORR_IDLE: begin
                if (clearAcc) begin
                    nextState = corrPkg::CORR_RUN;
                end
            end
            corrPkg::CORR_RUN: begin
                // abort wins over the last chip
                if (!enable) begin
                    nextState = corrPkg::CORR_IDLE;
                end else if (epochEnd) begin
                    nextState = corrPkg::CORR_DUMP;
                end
            end
            default: nextState = corrPkg::CORR_IDLE;
        endcase
    end

    always_ff @(posedge adc or negedge arstN) begin
        if (!arstN) begin
            state <= corrPkg::CORR_IDLE;
            done  <= 1'b0;
        end else begin
            state <= nextState;
            // sticky until the next accepted start
            if (clearAcc) begin
                done <= 1'b0;
            end else if (nextState == corrPkg::CORR_DUMP) begin
                done <= 1'b1;
            end
        end
    end

endmodule

/* src/corrPkg.sv */
package corrPkg;

    // bus widths
    localparam int ADR_W = 4;
    localparam int DAT_W = 32;

    // datapath widths
    // signed ADC samples
    localparam int SAMPLE_W = 4;
    // carrier and code phase accumulators
    localparam int NCO_W = 32;
    // chip counter, epoch length register
    localparam int EPOCH_W = 11;
    // PRN shift register
    localparam int PRN_W = 10;
    // signed I/Q accumulators
    localparam int ACC_W = 24;

    // value returned by REG_ID
    localparam logic [DAT_W-1:0] CORR_ID = 32'hC0AA0001;

    // word addresses of the register map
    typedef enum logic [ADR_W-1:0] {
        REG_ID         = 4'd0,
        REG_CFG        = 4'd1,
        REG_PHASE_RATE = 4'd2,
        REG_CODE_RATE  = 4'd3,
        REG_EPOCH_LEN  = 4'd4,
        REG_PRN_SEED   = 4'd5,
        REG_PRN_TAPS   = 4'd6,
        REG_START      = 4'd7,
        REG_STATUS     = 4'd8,
        REG_ACC_I      = 4'd9,
        REG_ACC_Q      = 4'd10
    } corrReg_t;

    // epoch FSM states
    typedef enum logic [1:0] {
        CORR_IDLE = 2'd0,
        CORR_RUN  = 2'd1,
        CORR_DUMP = 2'd2
    } corrState_t;

endpackage

/* src/corrRegs.sv */
`timescale 1ns/1ps

module corrRegs (
    input  logic                              adc,
    input  logic                              arstN,
    input  logic                              wbCyc,
    input  logic                              wbStb,
    input  logic                              wbWe,
    input  logic [corrPkg::ADR_W-1:0]         wbAdr,
    input  logic [corrPkg::DAT_W-1:0]         wbDatW,
    output logic [corrPkg::DAT_W-1:0]         wbDatR,
    output logic                              wbAck,
    input  logic                              done,
    input  logic                              run,
    input  logic signed [corrPkg::ACC_W-1:0]  accI,
    input  logic signed [corrPkg::ACC_W-1:0]  accQ,
    output logic                              startReq,
    output logic                              enable,
    output logic [corrPkg::NCO_W-1:0]         phaseRate,
    output logic [corrPkg::NCO_W-1:0]         codeRate,
    output logic [corrPkg::EPOCH_W-1:0]       epochLen,
    output logic [corrPkg::PRN_W-1:0]         prnSeed,
    output logic [corrPkg::PRN_W-1:0]         prnTaps
);

    corrPkg::corrReg_t regAdr;
    logic              busReq;
    logic              wrStb;

    assign regAdr = corrPkg::corrReg_t'(wbAdr);
    // new cycle seen, ack not yet given
    assign busReq = wbCyc && wbStb && !wbAck;
    assign wrStb  = busReq && wbWe;

    always_ff @(posedge adc or negedge arstN) begin
        if (!arstN) begin
            wbAck     <= 1'b0;
            startReq  <= 1'b0;
            enable    <= 1'b0;
            phaseRate <= '0;
            codeRate  <= '0;
            epochLen  <= '0;
            prnSeed   <= '0;
            prnTaps   <= '0;
        end else begin
            // single ack cycle, no wait states
            wbAck    <= busReq;
            // start pulse lines up with the ack cycle
            startReq <= wrStb && (regAdr == corrPkg::REG_START) && wbDatW[0];
            if (wrStb) begin
                case (regAdr)
                    corrPkg::REG_CFG:        enable    <= wbDatW[0];
                    corrPkg::REG_PHASE_RATE: phaseRate <= wbDatW[corrPkg::NCO_W-1:0];
                    corrPkg::REG_CODE_RATE:  codeRate  <= wbDatW[corrPkg::NCO_W-1:0];
                    corrPkg::REG_EPOCH_LEN:  epochLen  <= wbDatW[corrPkg::EPOCH_W-1:0];
                    corrPkg::REG_PRN_SEED:   prnSeed   <= wbDatW[corrPkg::PRN_W-1:0];
                    corrPkg::REG_PRN_TAPS:   prnTaps   <= wbDatW[corrPkg::PRN_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read mux, master holds the address until ack
    always_comb begin
        wbDatR = '0;
        case (regAdr)
            corrPkg::REG_ID:         wbDatR = corrPkg::CORR_ID;
            corrPkg::REG_CFG:        wbDatR[0] = enable;
            corrPkg::REG_PHASE_RATE: wbDatR[corrPkg::NCO_W-1:0] = phaseRate;
            corrPkg::REG_CODE_RATE:  wbDatR[corrPkg::NCO_W-1:0] = codeRate;
            corrPkg::REG_EPOCH_LEN:  wbDatR[corrPkg::EPOCH_W-1:0] = epochLen;
            corrPkg::REG_PRN_SEED:   wbDatR[corrPkg::PRN_W-1:0] = prnSeed;
            corrPkg::REG_PRN_TAPS:   wbDatR[corrPkg::PRN_W-1:0] = prnTaps;
            // busy is the run flag
            corrPkg::REG_STATUS:     wbDatR[1:0] = {run, done};
            corrPkg::REG_ACC_I:
                wbDatR = {{(corrPkg::DAT_W-corrPkg::ACC_W){accI[corrPkg::ACC_W-1]}}, accI};
            corrPkg::REG_ACC_Q:
                wbDatR = {{(corrPkg::DAT_W-corrPkg::ACC_W){accQ[corrPkg::ACC_W-1]}}, accQ};
            // start and unmapped words read zero
            default:                 wbDatR = '0;
        endcase
    end

endmodule

/* src/prnGen.sv */
`timescale 1ns/1ps

module prnGen (
    input  logic                      adc,
    input  logic                      arstN,
    input  logic                      run,
    input  logic                      chipTick,
    input  logic [corrPkg::PRN_W-1:0] prnSeed,
    input  logic [corrPkg::PRN_W-1:0] prnTaps,
    output logic                      chip
);

    logic [corrPkg::PRN_W-1:0] lfsr;
    logic                      feedback;

    // parity of the tapped bits
    assign feedback = ^(lfsr & prnTaps);

    // msb out, 1 means a -1 chip
    assign chip = lfsr[corrPkg::PRN_W-1];

    always_ff @(posedge adc or negedge arstN) begin
        if (!arstN) begin
            lfsr <= '0;
        end else if (!run) begin
            // reloaded every idle cycle
            lfsr <= prnSeed;
        end else if (chipTick) begin
            // fibonacci shift, new bit enters at bit 0
            lfsr <= {lfsr[corrPkg::PRN_W-2:0], feedback};
        end
    end

endmodule

/* verification/corrChannelTb.sv */
`timescale 1ns/1ps

module corrChannelTb;

    logic                                adc;
    logic                                arstN;
    logic                                wbCyc;
    logic                                wbStb;
    logic                                wbWe;
    logic [corrPkg::ADR_W-1:0]           wbAdr;
    logic [corrPkg::DAT_W-1:0]           wbDatW;
    logic [corrPkg::DAT_W-1:0]           wbDatR;
    logic                                wbAck;
    logic signed [corrPkg::SAMPLE_W-1:0] adcData;
    logic                                irq;

    logic [31:0] lcgState = 32'd70462;
    int          errors = 0;
    int          tests = 0;
    int          testStartFails = 0;
    logic [31:0] rd;
    // reference model results
    logic signed [corrPkg::ACC_W-1:0] modelI;
    logic signed [corrPkg::ACC_W-1:0] modelQ;

    corrChannel i_dut (.*);

    bind corrChannel corrChannelAssertions i_checks (
        .adc(adc), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
        .startReq(startReq), .enable(enable), .run(run), .done(done),
        .epochEnd(epochEnd), .irq(irq)
    );

    initial begin
        adc = 1'b0;
        forever #10 adc = ~adc;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] signExt(input logic [corrPkg::ACC_W-1:0] v);
        return {{(corrPkg::DAT_W-corrPkg::ACC_W){v[corrPkg::ACC_W-1]}}, v};
    endfunction

    function automatic int totalFails();
        return errors + i_dut.i_checks.assertFails;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("test %0d %s %s", tests, name, (totalFails() == testStartFails) ? "ok" : "FAILED");
        testStartFails = totalFails();
    endtask

    // one classic cycle, held until ack, released on the next edge
    task automatic busAccess(input logic we, input logic [corrPkg::ADR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge adc);
        #2;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdat;
        do begin
            @(posedge adc);
            #1;
            waited++;
        end while (!wbAck && waited < 10);
        rdat = wbDatR;
        if (!wbAck) begin
            $display("no ack from address %0d after %0d cycles", adr, waited);
            errors++;
        end
        @(posedge adc);
        #2;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbWrite(input logic [corrPkg::ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        busAccess(1'b1, adr, dat, ignored);
    endtask

    task automatic wbRead(input logic [corrPkg::ADR_W-1:0] adr, output logic [31:0] dat);
        busAccess(1'b0, adr, 32'd0, dat);
    endtask

    task automatic checkReadBack(input logic [corrPkg::ADR_W-1:0] adr, input logic [31:0] mask);
        logic [31:0] value;
        value = nextRand();
        wbWrite(adr, value);
        wbRead(adr, rd);
        checkValue("register read-back", rd, value & mask);
    endtask

    // configure, start, then drive samples and step the model once per run cycle
    task automatic runEpoch(input logic [31:0] phRate, input logic [31:0] cdRate, input int len,
                            input logic [31:0] seed, input logic [31:0] taps,
                            input bit randomSamples, input logic signed [3:0] fixedSample);
        logic [31:0]                      carr;
        logic [31:0]                      code;
        logic [32:0]                      codeSum;
        logic [corrPkg::PRN_W-1:0]        lfsr;
        logic [31:0]                      rnd;
        logic signed [3:0]                s;
        logic signed [corrPkg::ACC_W-1:0] sExt;
        int                               chips;
        wbWrite(corrPkg::REG_PHASE_RATE, phRate);
        wbWrite(corrPkg::REG_CODE_RATE, cdRate);
        wbWrite(corrPkg::REG_EPOCH_LEN, len);
        wbWrite(corrPkg::REG_PRN_SEED, seed);
        wbWrite(corrPkg::REG_PRN_TAPS, taps);
        wbWrite(corrPkg::REG_CFG, 32'd1);
        wbWrite(corrPkg::REG_START, 32'd1);
        // now 2 ns into the first run cycle
        carr = '0;
        code = '0;
        lfsr = seed[corrPkg::PRN_W-1:0];
        chips = 0;
        modelI = '0;
        modelQ = '0;
        while (chips < len) begin
            rnd = nextRand();
            s = randomSamples ? rnd[19:16] : fixedSample;
            adcData = s;
            sExt = {{(corrPkg::ACC_W-corrPkg::SAMPLE_W){s[3]}}, s};
            // chip 1 is -1, cos negative in quadrants 1 and 2, sin in 2 and 3
            modelI = (lfsr[corrPkg::PRN_W-1] ^ carr[31] ^ carr[30]) ? modelI - sExt : modelI + sExt;
            modelQ = (lfsr[corrPkg::PRN_W-1] ^ carr[31]) ? modelQ - sExt : modelQ + sExt;
            carr = carr + phRate;
            codeSum = {1'b0, code} + {1'b0, cdRate};
            code = codeSum[31:0];
            if (codeSum[32]) begin
                lfsr = {lfsr[corrPkg::PRN_W-2:0], ^(lfsr & taps[corrPkg::PRN_W-1:0])};
                chips++;
            end
            if (irq) begin
                $display("irq came before the last chip at %0t ns", $time);
                errors++;
            end
            @(posedge adc);
            #2;
        end
        checkValue("irq after the last run cycle", {31'd0, irq}, 32'd1);
        adcData = '0;
        wbRead(corrPkg::REG_STATUS, rd);
        checkValue("STATUS", rd, 32'd1);
        wbRead(corrPkg::REG_ACC_I, rd);
        checkValue("ACC_I", rd, signExt(modelI));
        wbRead(corrPkg::REG_ACC_Q, rd);
        checkValue("ACC_Q", rd, signExt(modelQ));
    endtask

    // bounded by the epoch lengths used below
    initial begin
        repeat ((13 + 20 + 8 + 5 + 100) * 40 + 2000) @(posedge adc);
        $display("timeout: the tests did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    initial begin
        arstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        adcData = '0;
        repeat (4) @(posedge adc);
        #2;
        arstN = 1'b1;

        checkValue("irq after reset", {31'd0, irq}, 32'd0);
        wbRead(corrPkg::REG_ID, rd);
        checkValue("ID", rd, corrPkg::CORR_ID);
        wbRead(4'hF, rd);
        checkValue("unmapped address", rd, 32'd0);
        finishTest("reset and ID");

        checkReadBack(corrPkg::REG_PHASE_RATE, 32'hFFFF_FFFF);
        checkReadBack(corrPkg::REG_CODE_RATE, 32'hFFFF_FFFF);
        checkReadBack(corrPkg::REG_EPOCH_LEN, (32'd1 << corrPkg::EPOCH_W) - 32'd1);
        checkReadBack(corrPkg::REG_PRN_SEED, (32'd1 << corrPkg::PRN_W) - 32'd1);
        checkReadBack(corrPkg::REG_PRN_TAPS, (32'd1 << corrPkg::PRN_W) - 32'd1);
        finishTest("register read-back");

        // two cycles per chip, irq 2N+1 cycles after the start ack
        runEpoch(nextRand(), 32'h8000_0000, 13, nextRand() | 32'd1, 32'h204, 1'b1, 4'sd0);
        finishTest("epoch timing");

        // carrier held in quadrant 0, only the chips flip the sign
        runEpoch(32'd0, 32'h4000_0000, 20, nextRand() | 32'd1, 32'h240, 1'b1, 4'sd0);
        finishTest("code wipe-off");

        // seed 0 gives +1 chips, 4 full carrier turns cancel
        runEpoch(32'h4000_0000, 32'h8000_0000, 8, 32'd0, 32'h204, 1'b0, 4'sd5);
        checkValue("ACC_Q over whole turns", rd, 32'd0);
        // two cycles per quadrant, a turn and a quarter leaves a residue
        runEpoch(32'h2000_0000, 32'h8000_0000, 5, 32'd0, 32'h204, 1'b0, 4'sd5);
        finishTest("carrier wipe-off");

        // start while disabled keeps done and the last result
        wbWrite(corrPkg::REG_CFG, 32'd0);
        wbWrite(corrPkg::REG_START, 32'd1);
        wbRead(corrPkg::REG_STATUS, rd);
        checkValue("STATUS after disabled start", rd, 32'd1);
        wbRead(corrPkg::REG_ACC_I, rd);
        checkValue("ACC_I after disabled start", rd, signExt(modelI));
        // abort mid-epoch by clearing enable
        wbWrite(corrPkg::REG_CFG, 32'd1);
        wbWrite(corrPkg::REG_EPOCH_LEN, 32'd100);
        wbWrite(corrPkg::REG_START, 32'd1);
        wbWrite(corrPkg::REG_CFG, 32'd0);
        repeat (20) @(posedge adc);
        wbRead(corrPkg::REG_STATUS, rd);
        checkValue("STATUS after abort", rd, 32'd0);
        // back in idle, so enabling again does not resume the epoch
        wbWrite(corrPkg::REG_CFG, 32'd1);
        wbRead(corrPkg::REG_STATUS, rd);
        checkValue("STATUS after re-enable", rd, 32'd0);
        finishTest("abort and disabled start");

        $display("%0d tests, %0d check errors, %0d assertion failures",
                 tests, errors, i_dut.i_checks.assertFails);
        if (totalFails() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verification/corrChannel_assertions.sv */
`timescale 1ns/1ps

module corrChannelAssertions (
    input logic adc,
    input logic arstN,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic startReq,
    input logic enable,
    input logic run,
    input logic done,
    input logic epochEnd,
    input logic irq
);

    // read by the testbench summary
    int assertFails = 0;

    task automatic noteFail(input string what);
        assertFails++;
        $error("%s", what);
    endtask

    // outputs quiet while reset is held
    resetQuiet: assert property (@(posedge adc) !arstN |-> !irq && !wbAck && !done)
        else noteFail("irq, ack or done high during reset");
    // single ack, one cycle after the strobe
    ackOneCycle: assert property (@(posedge adc) disable iff (!arstN) wbAck |=> !wbAck)
        else noteFail("ack held longer than one cycle");
    ackAfterStrobe: assert property (@(posedge adc) disable iff (!arstN)
        wbCyc && wbStb && !wbAck |=> wbAck)
        else noteFail("no ack on the cycle after the strobe");
    // irq is one dump cycle, then idle
    irqOneCycle: assert property (@(posedge adc) disable iff (!arstN) irq |=> !irq && !run)
        else noteFail("irq longer than one cycle or not followed by idle");
    irqWithDone: assert property (@(posedge adc) disable iff (!arstN) irq |-> done)
        else noteFail("irq without done");
    // accepted start from idle
    startEntersRun: assert property (@(posedge adc) disable iff (!arstN)
        startReq && enable && !run && !irq |=> run && !done)
        else noteFail("accepted start did not enter run with done cleared");
    lastChipToIrq: assert property (@(posedge adc) disable iff (!arstN) epochEnd |=> irq)
        else noteFail("last chip not followed by irq");
    // abort and ignored start, no run or irq once enable is low
    disabledQuiet: assert property (@(posedge adc) disable iff (!arstN)
        !enable |=> !irq && !run)
        else noteFail("irq or run after enable low");
    disabledNoDone: assert property (@(posedge adc) disable iff (!arstN)
        !enable && !done |=> !done)
        else noteFail("done set while enable low");

endmodule
